//--- common/cracker_pkg.sv
package cracker_pkg;

  localparam int NUM_LANES   = 4;
  localparam int PW_DIGITS   = 8;
  localparam int TIME_DIGITS = 10;
  localparam int HASH_BITS   = 128;
  localparam int RESET_HOLD  = 8;

  localparam int HOLD_BITS = $clog2(RESET_HOLD);
  localparam logic [HOLD_BITS-1:0] HOLD_LAST = HOLD_BITS'(RESET_HOLD - 1);

  // Digit spacing inside a field, ASCII bytes or packed BCD nibbles
  localparam int ASCII_STRIDE = 8;
  localparam int BCD_STRIDE   = 4;
  localparam int DIGIT_FIELD_BITS = TIME_DIGITS * ASCII_STRIDE;

  typedef logic [PW_DIGITS*8-1:0]        password_t;   // Most significant digit first
  typedef logic [HASH_BITS-1:0]          hash_t;
  typedef logic [TIME_DIGITS*4-1:0]      elapsed_t;
  typedef logic [DIGIT_FIELD_BITS-1:0]   digit_field_t;

  // Lanes split the 10^8 space into equal strides
  localparam password_t LANE_START [NUM_LANES] = '{"00000000", "25000000", "50000000", "75000000"};

  typedef enum logic [2:0] {
    S_IDLE       = 3'd0,
    S_HASH_RESET = 3'd1,
    S_LOAD       = 3'd2,
    S_HASH_WAIT  = 3'd3,
    S_COMPARE    = 3'd4,
    S_FOUND      = 3'd5
  } crack_state_e;

  typedef struct packed {
    password_t [NUM_LANES-1:0] lane;
  } cand_bundle_t;

  typedef struct packed {
    hash_t [NUM_LANES-1:0] lane;
  } hash_bundle_t;

  typedef struct packed {
    logic      hit;
    password_t password;
  } match_t;

  // Ripple decimal increment, only the low nibble of every digit slot is touched
  function automatic digit_field_t bcd_inc(input digit_field_t field, input int ndigits,
                                           input int stride);
    digit_field_t res;
    logic         carry;
    res   = field;
    carry = 1'b1;
    for (int d = 0; d < TIME_DIGITS; d++) begin
      if (carry && (d < ndigits)) begin
        if (res[d*stride +: 4] == 4'd9) begin
          res[d*stride +: 4] = 4'd0;
        end else begin
          res[d*stride +: 4] = res[d*stride +: 4] + 4'd1;
          carry = 1'b0;
        end
      end
    end
    return res;
  endfunction

endpackage

//--- logic/crack_ctrl.sv
`timescale 1ns/1ps

module crack_ctrl (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      start,
  input  logic                      hash_done,
  input  logic                      hit,
  output cracker_pkg::crack_state_e state,
  output logic                      hash_reset,
  output logic                      hash_start,
  output logic                      found
);

  cracker_pkg::crack_state_e           state_next;
  logic [cracker_pkg::HOLD_BITS-1:0]   hold_cnt;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state <= cracker_pkg::S_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Lanes need a long reset before each new job
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      hold_cnt <= '0;
    end else if (state == cracker_pkg::S_HASH_RESET) begin
      hold_cnt <= hold_cnt + 1'b1;
    end else begin
      hold_cnt <= '0;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      cracker_pkg::S_IDLE: begin
        if (start) state_next = cracker_pkg::S_HASH_RESET;
      end
      cracker_pkg::S_HASH_RESET: begin
        if (hold_cnt == cracker_pkg::HOLD_LAST) state_next = cracker_pkg::S_LOAD;
      end
      cracker_pkg::S_LOAD: begin
        state_next = cracker_pkg::S_HASH_WAIT;
      end
      cracker_pkg::S_HASH_WAIT: begin
        if (hash_done) state_next = cracker_pkg::S_COMPARE;
      end
      cracker_pkg::S_COMPARE: begin
        state_next = hit ? cracker_pkg::S_FOUND : cracker_pkg::S_HASH_RESET;
      end
      cracker_pkg::S_FOUND: begin
        if (start) state_next = cracker_pkg::S_IDLE;
      end
      default: state_next = cracker_pkg::S_IDLE;
    endcase
  end

  assign hash_reset = (state == cracker_pkg::S_HASH_RESET);
  assign hash_start = (state == cracker_pkg::S_LOAD);   // One cycle since S_LOAD never repeats
  assign found      = (state == cracker_pkg::S_FOUND);

endmodule

//--- logic/candidate_gen.sv
`timescale 1ns/1ps

module candidate_gen (
  input  logic                      clk,
  input  logic                      reset_n,
  input  cracker_pkg::crack_state_e state,
  input  logic                      hit,
  output cracker_pkg::cand_bundle_t candidates
);

  cracker_pkg::digit_field_t inc_field [cracker_pkg::NUM_LANES];
  logic                      advance;

  // Step only after a compare that found nothing
  assign advance = (state == cracker_pkg::S_COMPARE) && !hit;

  always_comb begin
    for (int l = 0; l < cracker_pkg::NUM_LANES; l++) begin
      inc_field[l] = cracker_pkg::bcd_inc(cracker_pkg::digit_field_t'(candidates.lane[l]),
                                          cracker_pkg::PW_DIGITS,
                                          cracker_pkg::ASCII_STRIDE);
    end
  end

  // Held across searches, so a new start resumes where the last one stopped
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      for (int l = 0; l < cracker_pkg::NUM_LANES; l++) begin
        candidates.lane[l] <= cracker_pkg::LANE_START[l];
      end
    end else if (advance) begin
      for (int l = 0; l < cracker_pkg::NUM_LANES; l++) begin
        candidates.lane[l] <= cracker_pkg::password_t'(inc_field[l]);   // Carry out of the top digit is dropped
      end
    end
  end

endmodule

//--- logic/match_unit.sv
`timescale 1ns/1ps

module match_unit (
  input  cracker_pkg::hash_bundle_t hashes,
  input  cracker_pkg::cand_bundle_t candidates,
  input  cracker_pkg::hash_t        target_hash,
  output cracker_pkg::match_t       match
);

  logic [cracker_pkg::NUM_LANES-1:0] lane_eq;

  always_comb begin
    for (int l = 0; l < cracker_pkg::NUM_LANES; l++) begin
      lane_eq[l] = (hashes.lane[l] == target_hash);
    end
  end

  // Walk from the top lane down so the lowest equal lane is written last
  always_comb begin
    match = '0;
    for (int l = cracker_pkg::NUM_LANES - 1; l >= 0; l--) begin
      if (lane_eq[l]) begin
        match.hit      = 1'b1;
        match.password = candidates.lane[l];
      end
    end
  end

endmodule

//--- logic/result_buffer.sv
`timescale 1ns/1ps

module result_buffer (
  input  logic                      clk,
  input  logic                      reset_n,
  input  cracker_pkg::crack_state_e state,
  input  cracker_pkg::match_t       match,
  output cracker_pkg::elapsed_t     elapsed,
  output cracker_pkg::password_t    password
);

  cracker_pkg::digit_field_t elapsed_inc;
  logic                      running;
  logic                      take_result;

  assign running     = (state != cracker_pkg::S_IDLE) && (state != cracker_pkg::S_FOUND);
  assign take_result = (state == cracker_pkg::S_COMPARE) && match.hit;

  assign elapsed_inc = cracker_pkg::bcd_inc(cracker_pkg::digit_field_t'(elapsed),
                                            cracker_pkg::TIME_DIGITS,
                                            cracker_pkg::BCD_STRIDE);

  // Cycle count of the search in BCD, frozen once the answer is shown
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      elapsed <= '0;
    end else if (state == cracker_pkg::S_IDLE) begin
      elapsed <= '0;
    end else if (running) begin
      elapsed <= cracker_pkg::elapsed_t'(elapsed_inc);
    end
  end

  // Candidates stop moving on a hit, but a copy keeps the answer independent of the lanes
  always_ff @(posedge clk) begin
    if (take_result) begin
      password <= match.password;
    end
  end

endmodule

//--- logic/password_cracker.sv
`timescale 1ns/1ps

module password_cracker (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      start,
  input  cracker_pkg::hash_t        target_hash,
  input  logic                      hash_done,
  input  cracker_pkg::hash_bundle_t hashes,
  output cracker_pkg::cand_bundle_t candidates,
  output logic                      hash_reset,
  output logic                      hash_start,
  output logic                      found,
  output cracker_pkg::password_t    password,
  output cracker_pkg::elapsed_t     elapsed,
  output cracker_pkg::crack_state_e state
);

  cracker_pkg::match_t match;

  crack_ctrl ctrl0 (
    .clk        (clk),
    .reset_n    (reset_n),
    .start      (start),
    .hash_done  (hash_done),
    .hit        (match.hit),
    .state      (state),
    .hash_reset (hash_reset),
    .hash_start (hash_start),
    .found      (found)
  );

  // Lanes sample these at hash_start and the values stay put until the compare
  candidate_gen gen0 (
    .clk        (clk),
    .reset_n    (reset_n),
    .state      (state),
    .hit        (match.hit),
    .candidates (candidates)
  );

  match_unit match0 (
    .hashes      (hashes),
    .candidates  (candidates),
    .target_hash (target_hash),
    .match       (match)
  );

  result_buffer result0 (
    .clk      (clk),
    .reset_n  (reset_n),
    .state    (state),
    .match    (match),
    .elapsed  (elapsed),
    .password (password)
  );

endmodule

//--- sim/password_cracker_asserts.sv
`timescale 1ns/1ps

module password_cracker_asserts (
  input logic                      clk,
  input logic                      reset_n,
  input cracker_pkg::crack_state_e state,
  input logic                      hash_reset,
  input logic                      hash_start,
  input logic                      found
);

  start_single_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    hash_start |=> !hash_start)
    else $error("hash_start stayed high for more than one cycle");

  reset_start_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
    !(hash_reset && hash_start))
    else $error("hash_reset and hash_start high together");

  found_in_found_state: assert property (@(posedge clk) disable iff (!reset_n)
    found |-> (state == cracker_pkg::S_FOUND))
    else $error("found high outside the found state");

endmodule

bind password_cracker password_cracker_asserts asserts0 (
  .clk        (clk),
  .reset_n    (reset_n),
  .state      (state),
  .hash_reset (hash_reset),
  .hash_start (hash_start),
  .found      (found)
);

//--- sim/tb_password_cracker.sv
`timescale 1ns/1ps

module tb_password_cracker;

  localparam int          NUM_SEARCHES   = 12;
  localparam int          TIMEOUT_CYCLES = NUM_SEARCHES * 7 * 30 + 200;
  localparam logic [31:0] LANE_STRIDE    = 32'd25000000;
  localparam logic [31:0] PW_SPACE       = 32'd100000000;

  logic                      clk;
  logic                      reset_n;
  logic                      start;
  cracker_pkg::hash_t        target_hash;
  logic                      hash_done;
  cracker_pkg::hash_bundle_t hashes;
  cracker_pkg::cand_bundle_t candidates;
  logic                      hash_reset;
  logic                      hash_start;
  logic                      found;
  cracker_pkg::password_t    password;
  cracker_pkg::elapsed_t     elapsed;
  cracker_pkg::crack_state_e state;

  logic [31:0]               rng_state;
  logic [31:0]               model_val [cracker_pkg::NUM_LANES];
  logic                      alias_on;
  cracker_pkg::password_t    alias_cand;
  cracker_pkg::hash_t        target;
  int                        elapsed_cnt;
  int                        cycle_count = 0;
  logic                      fail_printed = 1'b0;
  logic                      run_passed = 1'b0;

  password_cracker dut0 (
    .clk         (clk),
    .reset_n     (reset_n),
    .start       (start),
    .target_hash (target_hash),
    .hash_done   (hash_done),
    .hashes      (hashes),
    .candidates  (candidates),
    .hash_reset  (hash_reset),
    .hash_start  (hash_start),
    .found       (found),
    .password    (password),
    .elapsed     (elapsed),
    .state       (state)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rand_below(input logic [31:0] n);
    rng_state = lcg_step(rng_state);
    return (rng_state >> 8) % n;
  endfunction

  function automatic logic [31:0] step_value(input logic [31:0] v, input logic [31:0] n);
    return (v + n) % PW_SPACE;
  endfunction

  function automatic cracker_pkg::password_t to_ascii(input logic [31:0] value);
    cracker_pkg::password_t pw;
    logic [31:0]            v;
    v = value;
    for (int d = 0; d < cracker_pkg::PW_DIGITS; d++) begin
      pw[d*8 +: 8] = 8'h30 + 8'(v % 10);   // Lowest digit sits in the lowest byte
      v = v / 10;
    end
    return pw;
  endfunction

  function automatic cracker_pkg::elapsed_t to_bcd(input logic [31:0] value);
    cracker_pkg::elapsed_t e;
    logic [31:0]           v;
    v = value;
    for (int d = 0; d < cracker_pkg::TIME_DIGITS; d++) begin
      e[d*4 +: 4] = 4'(v % 10);
      v = v / 10;
    end
    return e;
  endfunction

  function automatic cracker_pkg::hash_t mix_hash(input cracker_pkg::password_t c);
    cracker_pkg::hash_t h;
    logic [31:0]        x;
    x = c[63:32] ^ c[31:0];
    for (int i = 0; i < 4; i++) begin
      x = lcg_step(x ^ {16'h0, c[i*16 +: 16]});
      h[i*32 +: 32] = x;
    end
    return h;
  endfunction

  // Stub lanes hash with mix_hash, plus one injected collision when alias_on is set
  function automatic cracker_pkg::hash_t lane_hash(input cracker_pkg::password_t c);
    if (alias_on && (c == alias_cand)) begin
      return target;
    end
    return mix_hash(c);
  endfunction

  function automatic cracker_pkg::cand_bundle_t model_bundle();
    cracker_pkg::cand_bundle_t b;
    for (int l = 0; l < cracker_pkg::NUM_LANES; l++) begin
      b.lane[l] = to_ascii(model_val[l]);
    end
    return b;
  endfunction

  // Lowest lane whose hash equals the target wins
  function automatic logic model_match(output cracker_pkg::password_t pw);
    logic hit;
    hit = 1'b0;
    pw  = '0;
    for (int l = 0; l < cracker_pkg::NUM_LANES; l++) begin
      if (!hit && (lane_hash(to_ascii(model_val[l])) == target)) begin
        hit = 1'b1;
        pw  = to_ascii(model_val[l]);
      end
    end
    return hit;
  endfunction

  task automatic fail_run();
    fail_printed = 1'b1;
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_state(input cracker_pkg::crack_state_e got,
                             input cracker_pkg::crack_state_e exp);
    if (got !== exp) begin
      $display("Mismatch state: got %h expected %h", got, exp);
      fail_run();
    end
  endtask

  task automatic check_password(input cracker_pkg::password_t got,
                                input cracker_pkg::password_t exp);
    if (got !== exp) begin
      $display("Mismatch password: got %h expected %h", got, exp);
      fail_run();
    end
  endtask

  task automatic check_elapsed(input cracker_pkg::elapsed_t got, input cracker_pkg::elapsed_t exp);
    if (got !== exp) begin
      $display("Mismatch elapsed: got %h expected %h", got, exp);
      fail_run();
    end
  endtask

  task automatic check_candidates(input cracker_pkg::cand_bundle_t got,
                                  input cracker_pkg::cand_bundle_t exp);
    if (got !== exp) begin
      $display("Mismatch candidates: got %h expected %h", got, exp);
      fail_run();
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
    elapsed_cnt++;
  endtask

  task automatic run_search(input int idx);
    int                     lane_a;
    int                     lane_b;
    logic [31:0]            steps;
    logic                   searching;
    cracker_pkg::password_t exp_pw;
    cracker_pkg::elapsed_t  frozen;
    int                     hold;
    lane_a = int'(rand_below(4));
    steps  = rand_below(7);
    target = mix_hash(to_ascii(step_value(model_val[lane_a], steps)));
    alias_on = (idx % 3 == 2);   // Second lane hits on the same round to exercise priority
    lane_b = (lane_a + 1 + int'(rand_below(3))) % cracker_pkg::NUM_LANES;
    alias_cand = to_ascii(step_value(model_val[lane_b], steps));
    target_hash = target;
    start = 1'b1;
    next_cycle();
    start = 1'b0;
    elapsed_cnt = 0;
    searching = 1'b1;
    while (searching) begin
      for (int i = 0; i < cracker_pkg::RESET_HOLD; i++) begin
        check_state(state, cracker_pkg::S_HASH_RESET);
        check_flag("hash_reset", hash_reset, 1'b1);
        check_flag("hash_start", hash_start, 1'b0);
        next_cycle();
      end
      check_state(state, cracker_pkg::S_LOAD);
      check_flag("hash_start", hash_start, 1'b1);
      check_flag("hash_reset", hash_reset, 1'b0);
      check_candidates(candidates, model_bundle());
      next_cycle();
      while (state == cracker_pkg::S_HASH_WAIT) begin
        check_flag("hash_start", hash_start, 1'b0);
        check_flag("hash_reset", hash_reset, 1'b0);
        next_cycle();
      end
      check_state(state, cracker_pkg::S_COMPARE);
      check_flag("hash_reset", hash_reset, 1'b0);
      searching = !model_match(exp_pw);
      next_cycle();
      if (searching) begin
        for (int l = 0; l < cracker_pkg::NUM_LANES; l++) begin
          model_val[l] = step_value(model_val[l], 32'd1);
        end
      end
    end
    check_state(state, cracker_pkg::S_FOUND);
    check_flag("found", found, 1'b1);
    check_password(password, exp_pw);
    check_elapsed(elapsed, to_bcd(32'(elapsed_cnt)));
    frozen = elapsed;
    hold = 2 + int'(rand_below(4));
    repeat (hold) begin
      next_cycle();
      check_state(state, cracker_pkg::S_FOUND);
      check_elapsed(elapsed, frozen);
    end
    start = 1'b1;
    next_cycle();
    start = 1'b0;
    check_state(state, cracker_pkg::S_IDLE);
    check_flag("found", found, 1'b0);
    next_cycle();
    check_elapsed(elapsed, '0);
    check_candidates(candidates, model_bundle());   // Held values carry into the next search
  endtask

  // Stub hash lanes with a random latency per job
  initial begin : hash_lanes
    cracker_pkg::cand_bundle_t sampled;
    int                        wait_cycles;
    hash_done = 1'b0;
    hashes    = '0;
    forever begin
      @(posedge clk);
      #1;
      if (reset_n && hash_start) begin
        sampled = candidates;
        wait_cycles = 1 + int'(rand_below(20));
        repeat (wait_cycles) begin
          @(posedge clk);
          #1;
        end
        for (int l = 0; l < cracker_pkg::NUM_LANES; l++) begin
          hashes.lane[l] = lane_hash(sampled.lane[l]);   // Held until the next job
        end
        hash_done = 1'b1;
        @(posedge clk);
        #1;
        check_state(state, cracker_pkg::S_COMPARE);   // The wait ends on this very strobe
        hash_done = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with the search still running", cycle_count);
      fail_run();
    end
  end

  initial begin : main_seq
    rng_state   = 32'h2264;
    reset_n     = 1'b0;
    start       = 1'b0;
    target_hash = '0;
    alias_on    = 1'b0;
    alias_cand  = '0;
    target      = '0;
    elapsed_cnt = 0;
    for (int l = 0; l < cracker_pkg::NUM_LANES; l++) begin
      model_val[l] = 32'(l) * LANE_STRIDE;
    end
    repeat (4) @(posedge clk);
    #1;
    reset_n = 1'b1;
    check_state(state, cracker_pkg::S_IDLE);
    check_flag("found", found, 1'b0);
    check_flag("hash_start", hash_start, 1'b0);
    check_flag("hash_reset", hash_reset, 1'b0);
    check_candidates(candidates, model_bundle());
    for (int s = 0; s < NUM_SEARCHES; s++) begin
      run_search(s);
    end
    run_passed = 1'b1;
    $display("All tests passed");
    $finish;
  end

  // Catches a run stopped by a failing assertion
  final begin
    if (!run_passed && !fail_printed) begin
      $display("Some tests failed");
    end
  end

endmodule

//--- sim.f
common/cracker_pkg.sv
logic/crack_ctrl.sv
logic/candidate_gen.sv
logic/match_unit.sv
logic/result_buffer.sv
logic/password_cracker.sv
sim/password_cracker_asserts.sv
sim/tb_password_cracker.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_password_cracker
FILELIST  := sim.f
LINTFLAGS := --lint-only --timing --assert --top-module $(TOP)
SIMFLAGS  := --binary --timing --assert --top-module $(TOP)
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
